// ==== project.f ====
verilog/conv1x1_pkg.sv
verilog/weight_fifo.sv
verilog/conv1x1_weight_buffer.sv
verilog/conv1x1_mac_lane.sv
verilog/conv1x1_controller.sv
verilog/conv1x1_result_serializer.sv
verilog/conv1x1_top.sv
verification/conv1x1_tb.sv

// ==== Bender.yml ====
package:
  name: conv1x1

sources:
  - files:
      - verilog/conv1x1_pkg.sv
      - verilog/weight_fifo.sv
      - verilog/conv1x1_weight_buffer.sv
      - verilog/conv1x1_mac_lane.sv
      - verilog/conv1x1_controller.sv
      - verilog/conv1x1_result_serializer.sv
      - verilog/conv1x1_top.sv
  - target: simulation
    files:
      - verification/conv1x1_tb.sv

// ==== verification/conv1x1_tb.sv ====
`timescale 1ns/1ps

module conv1x1_tb;

	import conv1x1_pkg::*;

	// Limit sits far above 42 pixels and two weight loads at worst case stall rates
	localparam int  TIMEOUT_CYCLES = 20000;
	localparam time DRIVE_DELAY    = 1ns;

	typedef enum logic [1:0] {
		READY_HIGH,
		READY_RANDOM,
		READY_LOW
	} ready_mode_t;

	logic  clk;
	logic  reset;
	logic  w_valid;
	logic  w_ready;
	data_t w_data;
	logic  px_valid;
	logic  px_ready;
	data_t px_data;
	logic  reload;
	logic  out_valid;
	logic  out_ready;
	acc_t  out_data;

	// Reference model state
	data_t wts [NUM_OUT_CH][NUM_IN_CH];
	data_t pix [NUM_IN_CH];
	acc_t  expected_q [$];
	acc_t  expected_word;

	ready_mode_t ready_mode;
	ready_mode_t drive_mode;
	int          cur_beat;
	int          stall_cycles;
	int          cycle_count  = 0;
	int          check_count  = 0;
	int          value_errors = 0;
	int          other_errors = 0;
	int unsigned seed_init;

	logic prev_stalled;
	acc_t prev_out_data;

	conv1x1_top u_conv1x1_top (
		.clk       (clk),
		.reset     (reset),
		.w_valid   (w_valid),
		.w_ready   (w_ready),
		.w_data    (w_data),
		.px_valid  (px_valid),
		.px_ready  (px_ready),
		.px_data   (px_data),
		.reload    (reload),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	////////////////////
	// Reporting
	////////////////////

	task automatic value_mismatch(input string name, input acc_t expected, input acc_t actual);
		$display("** Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
		value_errors++;
	endtask

	task automatic flag_mismatch(input string name, input logic expected, input logic actual);
		$display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
		value_errors++;
	endtask

	task automatic plain_failure(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		other_errors++;
	endtask

	task automatic finish_run();
		$display("Checked %0d results, %0d value errors, %0d other errors",
			check_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	////////////////////
	// Stimulus tasks
	////////////////////

	// Weights go out output-channel-major while px_ready stays low
	task automatic load_weights();
		for (int oc = 0; oc < NUM_OUT_CH; oc++) begin
			for (int ic = 0; ic < NUM_IN_CH; ic++) begin
				w_valid = 1'b1;
				w_data  = wts[oc][ic];
				do begin
					@(posedge clk);
					assert (px_ready === 1'b0) else flag_mismatch("px_ready", 1'b0, px_ready);
				end while (!w_ready);
				#DRIVE_DELAY;
				w_valid = 1'b0;
			end
		end
		// Now computing
		assert (w_ready === 1'b0) else flag_mismatch("w_ready", 1'b0, w_ready);
	endtask

	task automatic make_random_pixel();
		for (int ic = 0; ic < NUM_IN_CH; ic++) begin
			pix[ic] = data_t'($urandom);
		end
	endtask

	// Expected sums are queued before the beats go out
	task automatic send_pixel(input bit gaps);
		longint exact_sum;
		for (int oc = 0; oc < NUM_OUT_CH; oc++) begin
			exact_sum = 0;
			for (int ic = 0; ic < NUM_IN_CH; ic++) begin
				exact_sum += longint'(pix[ic]) * longint'(wts[oc][ic]);
			end
			// Low 32 bits of the exact sum
			expected_q.push_back(acc_t'(exact_sum));
		end
		for (int ic = 0; ic < NUM_IN_CH; ic++) begin
			if (gaps) begin
				repeat ($urandom_range(2, 0)) begin
					@(posedge clk);
					#DRIVE_DELAY;
				end
			end
			cur_beat = ic;
			px_valid = 1'b1;
			px_data  = pix[ic];
			do begin
				@(posedge clk);
			end while (!px_ready);
			#DRIVE_DELAY;
			px_valid = 1'b0;
		end
	endtask

	task automatic wait_for_drain();
		while (expected_q.size() != 0) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	////////////////////
	// Monitors
	////////////////////

	// Ready mode takes effect one drive delay after the edge
	always @(posedge clk) begin
		drive_mode = ready_mode;
		#DRIVE_DELAY;
		case (drive_mode)
			READY_HIGH:   out_ready = 1'b1;
			READY_RANDOM: out_ready = ($urandom_range(3, 0) != 0);
			default:      out_ready = 1'b0;
		endcase
	end

	// Result scoreboard
	always @(posedge clk) begin
		if (!reset && out_valid && out_ready) begin
			if (expected_q.size() == 0) begin
				plain_failure("result arrived with none expected");
			end else begin
				expected_word = expected_q.pop_front();
				check_count++;
				assert (out_data === expected_word) else
					value_mismatch("out_data", expected_word, out_data);
			end
		end
	end

	// Ready exclusion and output hold under back-pressure
	always @(posedge clk) begin
		if (reset) begin
			prev_stalled <= 1'b0;
		end else begin
			assert (!(w_ready && px_ready)) else plain_failure("w_ready and px_ready high together");
			if (prev_stalled) begin
				assert (out_valid === 1'b1) else flag_mismatch("out_valid", 1'b1, out_valid);
				assert (out_data === prev_out_data) else
					value_mismatch("out_data", prev_out_data, out_data);
			end
			prev_stalled  <= out_valid && !out_ready;
			prev_out_data <= out_data;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			plain_failure("run did not finish within the cycle limit");
			finish_run();
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		seed_init  = $urandom(23);
		reset      = 1'b1;
		w_valid    = 1'b0;
		w_data     = '0;
		px_valid   = 1'b0;
		px_data    = '0;
		reload     = 1'b0;
		out_ready  = 1'b0;
		ready_mode = READY_HIGH;
		cur_beat   = 0;
		repeat (16) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// Idle after reset
		@(posedge clk);
		assert (w_ready === 1'b1) else flag_mismatch("w_ready", 1'b1, w_ready);
		assert (px_ready === 1'b0) else flag_mismatch("px_ready", 1'b0, px_ready);
		assert (out_valid === 1'b0) else flag_mismatch("out_valid", 1'b0, out_valid);
		#DRIVE_DELAY;

		// Random first weight set
		for (int oc = 0; oc < NUM_OUT_CH; oc++) begin
			for (int ic = 0; ic < NUM_IN_CH; ic++) begin
				wts[oc][ic] = data_t'($urandom);
			end
		end
		load_weights();

		// Random gaps and random out_ready
		ready_mode = READY_RANDOM;
		repeat (10) begin
			make_random_pixel();
			send_pixel(1'b1);
		end

		// Back-to-back pixels keep the weights rotating
		ready_mode = READY_HIGH;
		repeat (20) begin
			make_random_pixel();
			send_pixel(1'b0);
		end

		// Full serializer stalls the next last beat
		wait_for_drain();
		ready_mode = READY_LOW;
		make_random_pixel();
		send_pixel(1'b0);
		make_random_pixel();
		stall_cycles = 0;
		fork
			send_pixel(1'b0);
			begin
				repeat (12) begin
					@(posedge clk);
					if (px_valid && cur_beat == NUM_IN_CH - 1) begin
						stall_cycles++;
						assert (px_ready === 1'b0) else flag_mismatch("px_ready", 1'b0, px_ready);
					end
				end
				#DRIVE_DELAY;
				ready_mode = READY_HIGH;
			end
		join
		assert (stall_cycles > 0) else plain_failure("last beat was never held off");

		// Reload between pixels
		wait_for_drain();
		reload = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		reload = 1'b0;
		assert (w_ready === 1'b1) else flag_mismatch("w_ready", 1'b1, w_ready);

		// Extreme weights make the sums wrap
		for (int ic = 0; ic < NUM_IN_CH; ic++) begin
			wts[0][ic] = 16'sh8000;
			wts[1][ic] = (ic % 2 == 1) ? 16'sh7fff : 16'sh8000;
		end
		load_weights();
		for (int ic = 0; ic < NUM_IN_CH; ic++) begin
			pix[ic] = 16'sh8000;
		end
		send_pixel(1'b0);
		for (int ic = 0; ic < NUM_IN_CH; ic++) begin
			pix[ic] = 16'sh7fff;
		end
		send_pixel(1'b0);

		// Random traffic on the new set
		ready_mode = READY_RANDOM;
		repeat (8) begin
			make_random_pixel();
			send_pixel(1'b1);
		end
		wait_for_drain();
		repeat (4) @(posedge clk);
		finish_run();
	end

endmodule

// ==== verilog/conv1x1_top.sv ====
`timescale 1ns/1ps

module conv1x1_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                w_valid,
	output logic                w_ready,
	input  conv1x1_pkg::data_t  w_data,
	input  logic                px_valid,
	output logic                px_ready,
	input  conv1x1_pkg::data_t  px_data,
	input  logic                reload,
	output logic                out_valid,
	input  logic                out_ready,
	output conv1x1_pkg::acc_t   out_data
);

	import conv1x1_pkg::*;

	logic [NUM_OUT_CH-1:0] wbuf_wr_en;
	logic                  wbuf_rd_en;
	logic                  flush;
	logic                  mac_first;
	logic                  mac_last;
	logic                  ser_free;

	data_t                 weight [NUM_OUT_CH];
	acc_t                  lane_sum [NUM_OUT_CH];
	logic [NUM_OUT_CH-1:0] lane_sums_valid;
	logic                  sums_valid;

	// Lanes run in lockstep
	assign sums_valid = &lane_sums_valid;

	conv1x1_controller u_controller (
		.clk        (clk),
		.reset      (reset),
		.w_valid    (w_valid),
		.px_valid   (px_valid),
		.reload     (reload),
		.ser_free   (ser_free),
		.sums_valid (sums_valid),
		.w_ready    (w_ready),
		.px_ready   (px_ready),
		.wbuf_wr_en (wbuf_wr_en),
		.wbuf_rd_en (wbuf_rd_en),
		.flush      (flush),
		.mac_first  (mac_first),
		.mac_last   (mac_last)
	);

	////////////////////
	// Per output channel
	////////////////////

	for (genvar i = 0; i < NUM_OUT_CH; i++) begin : g_lane
		conv1x1_weight_buffer u_weight_buffer (
			.clk     (clk),
			.reset   (reset),
			.flush   (flush),
			.wr_en   (wbuf_wr_en[i]),
			.wr_data (w_data),
			.rd_en   (wbuf_rd_en),
			.weight  (weight[i])
		);

		conv1x1_mac_lane u_mac_lane (
			.clk        (clk),
			.reset      (reset),
			.px_data    (px_data),
			.beat_valid (wbuf_rd_en),
			.mac_first  (mac_first),
			.mac_last   (mac_last),
			.weight     (weight[i]),
			.sum        (lane_sum[i]),
			.sums_valid (lane_sums_valid[i])
		);
	end

	conv1x1_result_serializer u_result_serializer (
		.clk        (clk),
		.reset      (reset),
		.sums_valid (sums_valid),
		.sums       (lane_sum),
		.out_ready  (out_ready),
		.ser_free   (ser_free),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

// ==== verilog/conv1x1_result_serializer.sv ====
`timescale 1ns/1ps

module conv1x1_result_serializer (
	input  logic               clk,
	input  logic               reset,
	input  logic               sums_valid,
	input  conv1x1_pkg::acc_t  sums [conv1x1_pkg::NUM_OUT_CH],
	input  logic               out_ready,
	output logic               ser_free,
	output logic               out_valid,
	output conv1x1_pkg::acc_t  out_data
);

	import conv1x1_pkg::*;

	// One pixel worth of sums
	acc_t    bank [NUM_OUT_CH];
	out_ch_t idx;
	logic    busy;
	logic    out_fire;
	logic    last_ch;

	assign out_fire = out_valid && out_ready;
	assign last_ch  = (idx == out_ch_t'(NUM_OUT_CH-1));

	assign ser_free  = !busy;
	assign out_valid = busy;
	assign out_data  = bank[idx];

	////////////////////
	// Bank capture
	////////////////////

	// Controller only lets sums arrive when the bank is free
	always_ff @(posedge clk) begin
		if (sums_valid) begin
			for (int i = 0; i < NUM_OUT_CH; i++) begin
				bank[i] <= sums[i];
			end
		end
	end

	////////////////////
	// Output sequencing
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			idx  <= '0;
		end else if (sums_valid) begin
			busy <= 1'b1;
			idx  <= '0;
		end else if (out_fire) begin
			if (last_ch) begin
				// All channels gone
				busy <= 1'b0;
				idx  <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/conv1x1_controller.sv ====
`timescale 1ns/1ps

module conv1x1_controller (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                w_valid,
	input  logic                                px_valid,
	input  logic                                reload,
	input  logic                                ser_free,
	input  logic                                sums_valid,
	output logic                                w_ready,
	output logic                                px_ready,
	output logic [conv1x1_pkg::NUM_OUT_CH-1:0]  wbuf_wr_en,
	output logic                                wbuf_rd_en,
	output logic                                flush,
	output logic                                mac_first,
	output logic                                mac_last
);

	import conv1x1_pkg::*;

	localparam int OUT_W  = $bits(out_ch_t);
	localparam int LOAD_W = OUT_W + $bits(in_ch_t);

	ctrl_state_t state;

	// Upper bits pick the buffer, lower bits the weight inside it
	logic [LOAD_W-1:0] load_cnt;
	in_ch_t            beat_cnt;
	// A pixel's sums are still in the MAC pipeline
	logic              in_flight;

	logic w_fire;
	logic px_fire;
	logic last_weight;
	out_ch_t load_sel;

	////////////////////
	// Handshakes
	////////////////////

	assign w_ready = (state == ST_LOAD);
	assign w_fire  = w_valid && w_ready;

	assign mac_first = (beat_cnt == '0);
	assign mac_last  = (beat_cnt == in_ch_t'(NUM_IN_CH-1));

	// Reload only between pixels, with the pipeline drained
	assign flush = reload && (state == ST_COMPUTE) && mac_first && !in_flight;

	// Last beat waits for an empty serializer and drained lanes
	assign px_ready = (state == ST_COMPUTE) && !flush &&
			(!mac_last || (ser_free && !in_flight));
	assign px_fire    = px_valid && px_ready;
	assign wbuf_rd_en = px_fire;

	// Route load beats to their buffer
	assign load_sel    = load_cnt[LOAD_W-1 -: OUT_W];
	assign last_weight = (load_cnt == {LOAD_W{1'b1}});

	always_comb begin
		wbuf_wr_en = '0;
		wbuf_wr_en[load_sel] = w_fire;
	end

	////////////////////
	// State and counters
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_LOAD;
			load_cnt <= '0;
			beat_cnt <= '0;
		end else begin
			case (state)
				ST_LOAD: begin
					if (w_fire) begin
						load_cnt <= load_cnt + 1'b1;
						if (last_weight) begin
							state <= ST_COMPUTE;
						end
					end
				end
				ST_COMPUTE: begin
					if (flush) begin
						state    <= ST_LOAD;
						load_cnt <= '0;
					end else if (px_fire) begin
						beat_cnt <= mac_last ? '0 : beat_cnt + 1'b1;
					end
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

	// Never set and cleared together, last beat needs it low
	always_ff @(posedge clk) begin
		if (reset) begin
			in_flight <= 1'b0;
		end else if (px_fire && mac_last) begin
			in_flight <= 1'b1;
		end else if (sums_valid) begin
			in_flight <= 1'b0;
		end
	end

endmodule

// ==== verilog/conv1x1_mac_lane.sv ====
`timescale 1ns/1ps

module conv1x1_mac_lane (
	input  logic                clk,
	input  logic                reset,
	input  conv1x1_pkg::data_t  px_data,
	input  logic                beat_valid,
	input  logic                mac_first,
	input  logic                mac_last,
	input  conv1x1_pkg::data_t  weight,
	output conv1x1_pkg::acc_t   sum,
	output logic                sums_valid
);

	import conv1x1_pkg::*;

	////////////////////
	// Stage 1, wait for weight
	////////////////////

	data_t px_q;
	logic  valid_q1;
	logic  first_q1;
	logic  last_q1;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q1 <= 1'b0;
			first_q1 <= 1'b0;
			last_q1  <= 1'b0;
		end else begin
			valid_q1 <= beat_valid;
			first_q1 <= beat_valid && mac_first;
			last_q1  <= beat_valid && mac_last;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_valid) begin
			px_q <= px_data;
		end
	end

	////////////////////
	// Stage 2, product
	////////////////////

	acc_t prod_q;
	logic valid_q2;
	logic first_q2;
	logic last_q2;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q2 <= 1'b0;
			first_q2 <= 1'b0;
			last_q2  <= 1'b0;
		end else begin
			valid_q2 <= valid_q1;
			first_q2 <= first_q1;
			last_q2  <= last_q1;
		end
	end

	// Sign extended operands, product wraps at ACC_W
	always_ff @(posedge clk) begin
		if (valid_q1) begin
			prod_q <= acc_t'(px_q) * acc_t'(weight);
		end
	end

	////////////////////
	// Stage 3, accumulate
	////////////////////

	acc_t acc_q;
	acc_t acc_next;

	// First beat of a pixel starts a fresh sum
	assign acc_next = first_q2 ? prod_q : acc_q + prod_q;

	always_ff @(posedge clk) begin
		if (valid_q2) begin
			acc_q <= acc_next;
		end
		if (valid_q2 && last_q2) begin
			sum <= acc_next;
		end
	end

	// One cycle pulse per finished pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			sums_valid <= 1'b0;
		end else begin
			sums_valid <= valid_q2 && last_q2;
		end
	end

endmodule

// ==== verilog/conv1x1_weight_buffer.sv ====
`timescale 1ns/1ps

module conv1x1_weight_buffer (
	input  logic                clk,
	input  logic                reset,
	input  logic                flush,
	input  logic                wr_en,
	input  conv1x1_pkg::data_t  wr_data,
	input  logic                rd_en,
	output conv1x1_pkg::data_t  weight
);

	import conv1x1_pkg::*;

	////////////////////
	// Input register
	////////////////////

	data_t in_data_q;
	logic  in_valid_q;

	// Incoming weight enters the FIFO one cycle later
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= wr_en;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			in_data_q <= wr_data;
		end
	end

	////////////////////
	// Recirculation
	////////////////////

	// High the cycle after a read while dout holds the read word
	logic  recirc_q;
	data_t fifo_din;
	data_t fifo_dout;
	logic  fifo_wr_en;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			recirc_q <= 1'b0;
		end else begin
			recirc_q <= rd_en;
		end
	end

	// Load and recirculation live in different controller states
	assign fifo_wr_en = in_valid_q || recirc_q;
	assign fifo_din   = recirc_q ? fifo_dout : in_data_q;

	weight_fifo #(
		.WIDTH ($bits(data_t)),
		.DEPTH (NUM_IN_CH)
	) u_weight_fifo (
		.clk   (clk),
		.reset (reset),
		.flush (flush),
		.wr_en (fifo_wr_en),
		.rd_en (rd_en),
		.din   (fifo_din),
		.dout  (fifo_dout),
		.full  (),
		.empty ()
	);

	// Word from the latest read
	assign weight = fifo_dout;

endmodule

// ==== verilog/weight_fifo.sv ====
`timescale 1ns/1ps

module weight_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  logic             wr_en,
	input  logic             rd_en,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout,
	output logic             full,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Storage
	logic [WIDTH-1:0] mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// One extra bit so DEPTH itself fits
	logic [PTR_W:0]   count;

	logic do_wr;
	logic do_rd;

	assign full  = (count == (PTR_W+1)'(DEPTH));
	assign empty = (count == '0);

	// Writes into a full FIFO and reads from an empty one are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Data path
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
		// Read word is registered and held between reads
		if (do_rd) begin
			dout <= mem[rd_ptr];
		end
	end

endmodule

// ==== verilog/conv1x1_pkg.sv ====
package conv1x1_pkg;

	////////////////////
	// Shape of the layer
	////////////////////

	// Input channels per pixel, also weights per buffer
	localparam int NUM_IN_CH = 4;

	// Output channels, one weight buffer and MAC lane each
	localparam int NUM_OUT_CH = 2;

	////////////////////
	// Word widths
	////////////////////

	// Activations and weights
	localparam int DATA_W = 16;

	// Accumulator and results, wraps modulo 2^32
	localparam int ACC_W = 32;

	////////////////////
	// Types
	////////////////////

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// Beat index inside a pixel
	typedef logic [$clog2(NUM_IN_CH)-1:0] in_ch_t;

	// Output channel index
	typedef logic [$clog2(NUM_OUT_CH)-1:0] out_ch_t;

	// Controller states
	typedef enum logic {
		ST_LOAD,
		ST_COMPUTE
	} ctrl_state_t;

endpackage
